/* Makefile */
# Verilator build and run of the fetch stage testbench
SIM   := verilator
FLAGS := --binary --timing --assert
TOP   := tb_fetch_stage
FLIST := flist.f
OBJ   := obj_dir
LOG   := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fail if the log reports failure"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ)
	./$(OBJ)/V$(TOP) | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "ALL CHECKS PASSED" $(LOG); then echo "no result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ) $(LOG)

/* fetch_ctrl_fsm.sv */
// Fetch control FSM, decides when a bus request is raised
// Stops fetching after an accepted bus error until the next redirect
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl_fsm (
  input  wire  clk,
  input  wire  rst_n,
  input  wire  pc_set_i,
  // From the transaction counter, room for one more request
  input  wire  can_issue_i,
  // Accepted response with err set
  input  wire  resp_err_i,
  output logic req_o,
  output logic busy_o
);

  import fetch_pkg::*;

  fetch_state_e state_q;
  fetch_state_e state_d;

  //////////////////////////////
  // Next state
  //////////////////////////////

  always_comb
  begin
    state_d = state_q;
    unique case (state_q)
      FETCH_IDLE:
      begin
        // Wait for the boot redirect
        if (pc_set_i)
        begin
          state_d = FETCH_RUN;
        end
      end
      FETCH_RUN:
      begin
        // A redirect in the same cycle overrides the error
        if (!pc_set_i && resp_err_i)
        begin
          state_d = FETCH_STOPPED;
        end
      end
      FETCH_STOPPED:
      begin
        if (pc_set_i)
        begin
          state_d = FETCH_RUN;
        end
      end
      default:
      begin
        state_d = FETCH_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= FETCH_IDLE;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  // No request while the address register is being redirected
  // Also held off in the cycle the error comes back
  assign req_o = (state_q == FETCH_RUN) && can_issue_i && !pc_set_i && !resp_err_i;

  // Request side of the busy status
  assign busy_o = req_o;

  // No error response can come back before the first request
  a_no_err_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
    resp_err_i |-> state_q != FETCH_IDLE);

endmodule

`default_nettype wire

/* fetch_if_id_reg.sv */
// IF/ID pipeline register between the prefetch FIFO head and decode
// Handles kill, halt and decode back-pressure, pops the FIFO on a transfer
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_if_id_reg (
  input  wire                       clk,
  input  wire                       rst_n,
  input  fetch_pkg::fetch_ctrl_t    ctrl_i,
  input  fetch_pkg::fetch_entry_t   head_i,
  input  wire                       head_valid_i,
  input  wire                       id_ready_i,
  output logic                      pop_o,
  output logic                      if_valid_o,
  output fetch_pkg::if_id_pipe_t    pipe_o
);

  import fetch_pkg::*;

  logic xfer;

  // Head offered to decode unless killed or halted
  assign if_valid_o = head_valid_i && !ctrl_i.kill_if && !ctrl_i.halt_if;
  assign xfer       = if_valid_o && id_ready_i;

  // Kill drops the head without handing it on
  assign pop_o = (ctrl_i.kill_if && head_valid_i) || xfer;

  //////////////////////////////
  // Pipe register
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pipe_o.instr_valid <= 1'b0;
      pipe_o.instr       <= `FETCH_INSTR_RESET;
      pipe_o.pc          <= '0;
      pipe_o.bus_err     <= 1'b0;
    end
    else if (xfer)
    begin
      pipe_o.instr_valid <= 1'b1;
      pipe_o.instr       <= head_i.instr;
      pipe_o.pc          <= head_i.addr;
      pipe_o.bus_err     <= head_i.bus_err;
    end
    else if (id_ready_i)
    begin
      // Decode took the old one, nothing new behind it
      pipe_o.instr_valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* fetch_instr_fifo.sv */
// Prefetch FIFO of fetched words with their address and bus error flag
// Flush empties it in one cycle and wins over push and pop
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_instr_fifo #(
  parameter int DEPTH = `FETCH_FIFO_DEPTH
) (
  input  wire                            clk,
  input  wire                            rst_n,
  input  wire                            flush_i,
  input  wire                            push_i,
  input  fetch_pkg::fetch_entry_t        push_data_i,
  input  wire                            pop_i,
  output fetch_pkg::fetch_entry_t        head_o,
  output logic                           valid_o,
  output logic [$clog2(DEPTH+1)-1:0]     level_o
);

  import fetch_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int LVL_W = $clog2(DEPTH + 1);

  fetch_entry_t     mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [LVL_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  assign do_push = push_i && !flush_i;
  assign do_pop  = pop_i && valid_o && !flush_i;

  //////////////////////////////
  // Pointers and level
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else if (flush_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (do_push)
      begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop)
      begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Level moves only when one side acts alone
      if (do_push && !do_pop)
      begin
        count_q <= count_q + 1'b1;
      end
      else if (do_pop && !do_push)
      begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk)
  begin
    if (do_push)
    begin
      mem[wr_ptr_q] <= push_data_i;
    end
  end

  assign head_o  = mem[rd_ptr_q];
  assign valid_o = (count_q != '0);
  assign level_o = count_q;

  // Transaction counter reserves a slot per request
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    do_push |-> count_q != LVL_W'(DEPTH));

endmodule

`default_nettype wire

/* fetch_macros.svh */
// Sizes and reset values for the instruction fetch stage
// Included by the package and by every fetch module that needs a width or limit
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// Address and instruction word width
`define FETCH_ADDR_W 32

// Prefetch FIFO entries
`define FETCH_FIFO_DEPTH 4

// FIFO level width, counts 0 to FETCH_FIFO_DEPTH
`define FETCH_LVL_W $clog2(`FETCH_FIFO_DEPTH + 1)

// Granted bus requests still waiting for rvalid
`define FETCH_MAX_OUTSTANDING 2

// Fetch address after reset, before the boot redirect
`define FETCH_PC_RESET 32'h0000_0000

// addi x0, x0, 0
`define FETCH_INSTR_RESET 32'h0000_0013

`endif

/* fetch_pc_select.sv */
// Redirect target selection and the fetch address register
// The register loads a target on pc_set and steps by one word per bus grant
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_pc_select (
  input  wire                          clk,
  input  wire                          rst_n,
  input  fetch_pkg::fetch_ctrl_t       ctrl_i,
  input  fetch_pkg::fetch_targets_t    targets_i,
  // Grant already qualified with req
  input  wire                          gnt_i,
  output logic [`FETCH_ADDR_W-1:0]     fetch_addr_o,
  output logic                         csr_mtvec_init_o
);

  import fetch_pkg::*;

  logic [`FETCH_ADDR_W-1:0] target;
  logic [`FETCH_ADDR_W-1:0] fetch_addr_q;

  // Target mux
  always_comb
  begin
    unique case (ctrl_i.pc_mux)
      PC_JUMP:      target = targets_i.jump_target;
      PC_BRANCH:    target = targets_i.branch_target;
      // All exceptions share the base
      PC_EXCEPTION: target = {targets_i.mtvec_base, 8'h00};
      // Vectored, one word per irq_id
      PC_IRQ:       target = {targets_i.mtvec_base, 1'b0, ctrl_i.irq_id, 2'b00};
      PC_MRET:      target = {targets_i.mepc[`FETCH_ADDR_W-1:2], 2'b00};
      default:      target = {targets_i.boot_addr[`FETCH_ADDR_W-1:2], 2'b00};
    endcase
  end

  // Redirect has priority over the sequential step
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      fetch_addr_q <= `FETCH_PC_RESET;
    end
    else if (ctrl_i.pc_set)
    begin
      fetch_addr_q <= target;
    end
    else if (gnt_i)
    begin
      fetch_addr_q <= fetch_addr_q + `FETCH_ADDR_W'(4);
    end
  end

  assign fetch_addr_o = fetch_addr_q;

  // CSR file sets up mtvec on the boot redirect
  assign csr_mtvec_init_o = ctrl_i.pc_set && (ctrl_i.pc_mux == PC_BOOT);

  // Controller must only send defined sources
  a_legal_pc_mux: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl_i.pc_set |-> ctrl_i.pc_mux inside {PC_BOOT, PC_JUMP, PC_BRANCH,
                                            PC_EXCEPTION, PC_IRQ, PC_MRET});

endmodule

`default_nettype wire

/* fetch_pkg.sv */
// Shared enums and packed structs of the fetch stage
// Imported by the fetch RTL and by its testbench
`default_nettype none

`include "fetch_macros.svh"

package fetch_pkg;

  //////////////////////////////
  // Enums
  //////////////////////////////

  // Redirect target source
  typedef enum logic [2:0] {
    PC_BOOT      = 3'd0,
    PC_JUMP      = 3'd1,
    PC_BRANCH    = 3'd2,
    PC_EXCEPTION = 3'd3,
    PC_IRQ       = 3'd4,
    PC_MRET      = 3'd5
  } pc_mux_e;

  // Fetch controller states
  typedef enum logic [1:0] {
    FETCH_IDLE    = 2'd0,
    FETCH_RUN     = 2'd1,
    FETCH_STOPPED = 2'd2
  } fetch_state_e;

  //////////////////////////////
  // Structs
  //////////////////////////////

  // Command from the core controller
  typedef struct packed {
    logic    pc_set;
    pc_mux_e pc_mux;
    logic [4:0] irq_id;
    logic    kill_if;
    logic    halt_if;
  } fetch_ctrl_t;

  // Candidate redirect addresses
  typedef struct packed {
    logic [`FETCH_ADDR_W-1:0] boot_addr;
    logic [`FETCH_ADDR_W-1:0] jump_target;
    logic [`FETCH_ADDR_W-1:0] branch_target;
    // Upper bits only, low byte is implied zero
    logic [`FETCH_ADDR_W-9:0] mtvec_base;
    logic [`FETCH_ADDR_W-1:0] mepc;
  } fetch_targets_t;

  // One prefetch FIFO entry
  typedef struct packed {
    logic [`FETCH_ADDR_W-1:0] instr;
    logic [`FETCH_ADDR_W-1:0] addr;
    logic                     bus_err;
  } fetch_entry_t;

  // IF/ID pipeline register contents
  typedef struct packed {
    logic                     instr_valid;
    logic [`FETCH_ADDR_W-1:0] instr;
    logic [`FETCH_ADDR_W-1:0] pc;
    logic                     bus_err;
  } if_id_pipe_t;

endpackage

`default_nettype wire

/* fetch_stage.sv */
// Instruction fetch stage top level
// Connects the instruction bus and the decode side to the address, control and buffer blocks
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_stage (
  input  wire                          clk,
  input  wire                          rst_n,
  // Controller
  input  fetch_pkg::fetch_ctrl_t       ctrl_i,
  input  fetch_pkg::fetch_targets_t    targets_i,
  // Instruction bus
  output logic                         req_o,
  output logic [`FETCH_ADDR_W-1:0]     addr_o,
  input  wire                          gnt_i,
  input  wire                          rvalid_i,
  input  wire [`FETCH_ADDR_W-1:0]      rdata_i,
  input  wire                          err_i,
  // Decode
  output logic                         if_valid_o,
  input  wire                          id_ready_i,
  output fetch_pkg::if_id_pipe_t       if_id_pipe_o,
  // Status
  output logic [`FETCH_ADDR_W-1:0]     pc_if_o,
  output logic                         if_busy_o,
  output logic                         csr_mtvec_init_o
);

  import fetch_pkg::*;

  logic                     bus_gnt;
  logic                     can_issue;
  logic                     accept;
  logic                     resp_err;
  logic                     fsm_busy;
  logic                     txn_busy;
  logic [`FETCH_ADDR_W-1:0] resp_addr;
  logic [`FETCH_LVL_W-1:0]  fifo_level;
  fetch_entry_t             push_entry;
  fetch_entry_t             fifo_head;
  logic                     fifo_valid;
  logic                     fifo_pop;

  assign bus_gnt  = req_o && gnt_i;
  // Error only counts on a response that is kept
  assign resp_err = accept && err_i;

  assign push_entry.instr   = rdata_i;
  assign push_entry.addr    = resp_addr;
  assign push_entry.bus_err = err_i;

  assign pc_if_o   = fifo_head.addr;
  assign if_busy_o = fsm_busy || txn_busy;

  fetch_pc_select u_pc_select (
    .clk              (clk),
    .rst_n            (rst_n),
    .ctrl_i           (ctrl_i),
    .targets_i        (targets_i),
    .gnt_i            (bus_gnt),
    .fetch_addr_o     (addr_o),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  fetch_ctrl_fsm u_ctrl_fsm (
    .clk         (clk),
    .rst_n       (rst_n),
    .pc_set_i    (ctrl_i.pc_set),
    .can_issue_i (can_issue),
    .resp_err_i  (resp_err),
    .req_o       (req_o),
    .busy_o      (fsm_busy)
  );

  // Error also turns the responses behind it stale
  fetch_txn_counter u_txn_counter (
    .clk          (clk),
    .rst_n        (rst_n),
    .gnt_i        (gnt_i),
    .req_i        (req_o),
    .rvalid_i     (rvalid_i),
    .pc_set_i     (ctrl_i.pc_set || resp_err),
    .addr_i       (addr_o),
    .fifo_level_i (fifo_level),
    .can_issue_o  (can_issue),
    .accept_o     (accept),
    .busy_o       (txn_busy),
    .resp_addr_o  (resp_addr)
  );

  fetch_instr_fifo u_instr_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (ctrl_i.pc_set),
    .push_i      (accept),
    .push_data_i (push_entry),
    .pop_i       (fifo_pop),
    .head_o      (fifo_head),
    .valid_o     (fifo_valid),
    .level_o     (fifo_level)
  );

  fetch_if_id_reg u_if_id_reg (
    .clk          (clk),
    .rst_n        (rst_n),
    .ctrl_i       (ctrl_i),
    .head_i       (fifo_head),
    .head_valid_i (fifo_valid),
    .id_ready_i   (id_ready_i),
    .pop_o        (fifo_pop),
    .if_valid_o   (if_valid_o),
    .pipe_o       (if_id_pipe_o)
  );

endmodule

`default_nettype wire

/* fetch_txn_counter.sv */
// Tracks granted bus requests, stale responses after a redirect and response addresses
// Also gates new requests against FIFO room and the outstanding limit
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_txn_counter (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          gnt_i,
  input  wire                          req_i,
  input  wire                          rvalid_i,
  // Marks every unanswered request as stale
  input  wire                          pc_set_i,
  input  wire [`FETCH_ADDR_W-1:0]      addr_i,
  input  wire [`FETCH_LVL_W-1:0]       fifo_level_i,
  output logic                         can_issue_o,
  output logic                         accept_o,
  output logic                         busy_o,
  output logic [`FETCH_ADDR_W-1:0]     resp_addr_o
);

  localparam int MAX   = `FETCH_MAX_OUTSTANDING;
  localparam int CNT_W = $clog2(MAX + 1);
  localparam int PTR_W = (MAX > 1) ? $clog2(MAX) : 1;
  localparam int SUM_W = `FETCH_LVL_W + 1;

  logic                     gnt;
  logic [CNT_W-1:0]         out_q;
  logic [CNT_W-1:0]         out_d;
  logic [CNT_W-1:0]         discard_q;
  logic [CNT_W-1:0]         discard_d;
  logic [SUM_W-1:0]         pending;
  logic [PTR_W-1:0]         wr_ptr_q;
  logic [PTR_W-1:0]         rd_ptr_q;
  logic [`FETCH_ADDR_W-1:0] addr_mem [MAX];

  // Transfer only when both sides agree
  assign gnt = req_i && gnt_i;

  // Outstanding after this cycle
  always_comb
  begin
    out_d = out_q;
    if (gnt && !rvalid_i)
    begin
      out_d = out_q + 1'b1;
    end
    else if (!gnt && rvalid_i)
    begin
      out_d = out_q - 1'b1;
    end
  end

  // Stale responses still to come back
  always_comb
  begin
    discard_d = discard_q;
    if (pc_set_i)
    begin
      discard_d = out_d;
    end
    else if (rvalid_i && (discard_q != '0))
    begin
      discard_d = discard_q - 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      out_q     <= '0;
      discard_q <= '0;
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
    end
    else
    begin
      out_q     <= out_d;
      discard_q <= discard_d;
      if (gnt)
      begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(MAX - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      // Stale responses pop their address too
      if (rvalid_i)
      begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(MAX - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
    end
  end

  // Address queue, in bus order
  always_ff @(posedge clk)
  begin
    if (gnt)
    begin
      addr_mem[wr_ptr_q] <= addr_i;
    end
  end

  assign resp_addr_o = addr_mem[rd_ptr_q];
  assign accept_o    = rvalid_i && (discard_q == '0);
  assign busy_o      = (out_q != '0);

  // Every in-flight request reserves one FIFO slot
  assign pending     = SUM_W'(fifo_level_i) + SUM_W'(out_q);
  assign can_issue_o = (out_q < CNT_W'(MAX)) && (pending < SUM_W'(`FETCH_FIFO_DEPTH));

  // Bus must answer only granted requests
  a_rvalid_has_txn: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid_i |-> out_q != '0);

endmodule

`default_nettype wire

/* flist.f */
+incdir+.
fetch_pkg.sv
fetch_pc_select.sv
fetch_ctrl_fsm.sv
fetch_txn_counter.sv
fetch_instr_fifo.sv
fetch_if_id_reg.sv
fetch_stage.sv
tb_fetch_clkgen.sv
tb_fetch_stage.sv

/* tb_fetch_clkgen.sv */
// Testbench clock and reset source for the fetch stage
// 10 ns clock, reset held low for the first 8 rising edges
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_clkgen (
  output logic clk_o,
  output logic rst_n_o
);

  initial
  begin
    clk_o   = 1'b0;
    rst_n_o = 1'b0;
    repeat (8) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

  // Half period of 5 ns
  always #5 clk_o = ~clk_o;

endmodule

`default_nettype wire

/* tb_fetch_stage.sv */
// Testbench of the fetch stage with a random-latency bus memory and a FIFO reference model
// Applies a table of redirects and decode behaviors, then prints the totals
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module tb_fetch_stage;

  import fetch_pkg::*;

  localparam int          NUM_STIM = 12;
  localparam int          DEPTH    = `FETCH_FIFO_DEPTH;
  localparam int          MAX_OUT  = `FETCH_MAX_OUTSTANDING;
  localparam logic [31:0] DATA_KEY = 32'hA5C3_5A3C;
  // Bus errors come back for this address window
  localparam logic [31:0] ERR_LO   = 32'h0000_9000;
  localparam logic [31:0] ERR_HI   = 32'h0000_9100;

  // One stimulus table entry
  typedef struct packed {
    pc_mux_e     mux;
    logic [31:0] addr;
    logic [4:0]  irq_id;
    int          n;
    int          ready_pct;
    int          halt_pct;
    int          kill_pct;
    logic        stop;
  } stim_t;

  logic                      clk;
  logic                      rst_n;
  fetch_ctrl_t               ctrl;
  fetch_targets_t            targets;
  logic                      req;
  logic [`FETCH_ADDR_W-1:0]  addr;
  logic                      gnt    = 1'b0;
  logic                      rvalid = 1'b0;
  logic [`FETCH_ADDR_W-1:0]  rdata  = '0;
  logic                      err    = 1'b0;
  logic                      if_valid;
  logic                      id_ready;
  if_id_pipe_t               pipe_out;
  logic [`FETCH_ADDR_W-1:0]  pc_if;
  logic                      if_busy;
  logic                      mtvec_init;

  int    seed   = 46404;
  int    checks = 0;
  int    errors = 0;
  stim_t tbl [NUM_STIM];

  // Bus memory model, granted requests in order
  logic [31:0] bus_addr_q [$];
  int          bus_due_q [$];
  int          bus_gen_q [$];
  logic [31:0] resp_addr = '0;
  int          resp_gen  = 0;
  int          cyc       = 0;
  // Redirect generation, responses of older ones are stale
  int          gen       = 0;

  // Reference FIFO contents and pipe tracking
  logic [31:0] mdl_q [$];
  logic        stopped    = 1'b0;
  logic        xfer_prev  = 1'b0;
  logic        prev_ready = 1'b1;
  if_id_pipe_t prev_pipe  = '0;
  logic [31:0] exp_addr   = '0;

  // Observed since the last redirect
  int          got      = 0;
  int          kills    = 0;
  logic [31:0] first_pc = '0;
  logic        last_err = 1'b0;

  // Redirect target of the running entry and the next granted address
  logic [31:0] exp_t     = '0;
  logic [31:0] next_addr = '0;

  tb_fetch_clkgen u_clkgen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  fetch_stage dut (
    .clk              (clk),
    .rst_n            (rst_n),
    .ctrl_i           (ctrl),
    .targets_i        (targets),
    .req_o            (req),
    .addr_o           (addr),
    .gnt_i            (gnt),
    .rvalid_i         (rvalid),
    .rdata_i          (rdata),
    .err_i            (err),
    .if_valid_o       (if_valid),
    .id_ready_i       (id_ready),
    .if_id_pipe_o     (pipe_out),
    .pc_if_o          (pc_if),
    .if_busy_o        (if_busy),
    .csr_mtvec_init_o (mtvec_init)
  );

  //////////////////////////////
  // Helpers
  //////////////////////////////

  task automatic check(input string what, input logic [65:0] actual,
                       input logic [65:0] expected);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("[ERROR] %0t ns %s: got %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  function automatic logic pct_hit(input int pct);
    return int'($unsigned($random(seed)) % 100) < pct;
  endfunction

  function automatic logic in_window(input logic [31:0] a);
    return (a >= ERR_LO) && (a < ERR_HI);
  endfunction

  // Handler or return address per redirect source
  function automatic logic [31:0] redirect_target(input stim_t s);
    case (s.mux)
      PC_JUMP, PC_BRANCH: return s.addr;
      PC_EXCEPTION:       return s.addr & 32'hFFFF_FF00;
      PC_IRQ:             return (s.addr & 32'hFFFF_FF00) + 32'(s.irq_id) * 32'd4;
      default:            return s.addr & 32'hFFFF_FFFC;
    endcase
  endfunction

  // Unused targets get distinct decoys so a wrong mux choice shows up
  function automatic fetch_targets_t make_targets(input stim_t s);
    fetch_targets_t tg;
    tg.boot_addr     = 32'h0000_0F00;
    tg.jump_target   = 32'h0000_0E00;
    tg.branch_target = 32'h0000_0D00;
    tg.mtvec_base    = 24'h00_000C;
    tg.mepc          = 32'h0000_0B00;
    case (s.mux)
      PC_BOOT:   tg.boot_addr     = s.addr;
      PC_JUMP:   tg.jump_target   = s.addr;
      PC_BRANCH: tg.branch_target = s.addr;
      PC_MRET:   tg.mepc          = s.addr;
      default:   tg.mtvec_base    = s.addr[31:8];
    endcase
    return tg;
  endfunction

  //////////////////////////////
  // Per-cycle model and bus
  //////////////////////////////

  // Runs right at the rising edge, so all DUT outputs are still the settled pre-edge values
  task automatic step();
    int   outst;
    int   lat;
    logic exp_valid;
    cyc++;
    if (!rst_n)
    begin
      gnt    <= 1'b0;
      rvalid <= 1'b0;
    end
    else
    begin
      // A response on the bus still counts as outstanding in its own cycle
      outst = bus_addr_q.size() + (rvalid ? 1 : 0);
      check("csr_mtvec_init_o", 66'(mtvec_init), 66'(ctrl.pc_set && ctrl.pc_mux == PC_BOOT));
      check("if_busy_o", 66'(if_busy), 66'(req || outst != 0));
      if (req)
      begin
        check("req_o at outstanding limit", 66'(outst < MAX_OUT), 66'(1));
        check("req_o with no FIFO room", 66'(mdl_q.size() + outst < DEPTH), 66'(1));
      end
      if (stopped)
      begin
        check("req_o after bus error", 66'(req), 66'(0));
      end
      // Pipe register result of the previous cycle
      if (xfer_prev)
      begin
        check("pipe instr_valid", 66'(pipe_out.instr_valid), 66'(1));
        check("pipe pc", 66'(pipe_out.pc), 66'(exp_addr));
        check("pipe instr", 66'(pipe_out.instr), 66'(exp_addr ^ DATA_KEY));
        check("pipe bus_err", 66'(pipe_out.bus_err), 66'(in_window(exp_addr)));
        if (got == 0)
        begin
          first_pc = pipe_out.pc;
        end
        got++;
        last_err = pipe_out.bus_err;
      end
      else if (prev_ready)
      begin
        check("pipe cleared without transfer", 66'(pipe_out.instr_valid), 66'(0));
      end
      else
      begin
        check("pipe held while not ready", 66'(pipe_out), 66'(prev_pipe));
      end
      prev_ready = id_ready;
      prev_pipe  = pipe_out;
      // FIFO head toward decode
      xfer_prev = 1'b0;
      if (mdl_q.size() != 0)
      begin
        check("pc_if_o", 66'(pc_if), 66'(mdl_q[0]));
      end
      if (ctrl.kill_if && mdl_q.size() != 0)
      begin
        void'(mdl_q.pop_front());
        kills++;
      end
      exp_valid = (mdl_q.size() != 0) && !ctrl.kill_if && !ctrl.halt_if;
      check("if_valid_o", 66'(if_valid), 66'(exp_valid));
      if (exp_valid && id_ready)
      begin
        exp_addr  = mdl_q.pop_front();
        xfer_prev = 1'b1;
      end
      // Response kept only if it belongs to the current redirect
      if (rvalid && !ctrl.pc_set && resp_gen == gen && !stopped)
      begin
        mdl_q.push_back(resp_addr);
        if (in_window(resp_addr))
        begin
          stopped = 1'b1;
        end
      end
      if (req && gnt)
      begin
        // Granted addresses run on from the target one word at a time
        check("addr_o on grant", 66'(addr), 66'(next_addr));
        next_addr = next_addr + 32'd4;
        lat = 1 + int'($unsigned($random(seed)) % 3);
        bus_addr_q.push_back(addr);
        bus_due_q.push_back(cyc + lat - 1);
        bus_gen_q.push_back(gen);
      end
      // Redirect flushes and restarts the count
      if (ctrl.pc_set)
      begin
        mdl_q.delete();
        gen++;
        stopped   = 1'b0;
        got       = 0;
        kills     = 0;
        next_addr = exp_t;
      end
      // Bus outputs for the next cycle
      gnt <= pct_hit(70);
      if (bus_addr_q.size() != 0 && bus_due_q[0] <= cyc)
      begin
        resp_addr = bus_addr_q.pop_front();
        resp_gen  = bus_gen_q.pop_front();
        void'(bus_due_q.pop_front());
        rvalid <= 1'b1;
        rdata  <= resp_addr ^ DATA_KEY;
        err    <= in_window(resp_addr);
      end
      else
      begin
        rvalid <= 1'b0;
        err    <= 1'b0;
      end
    end
  endtask

  task automatic tick();
    @(posedge clk);
    step();
  endtask

  task automatic load_table();
    // mux, address, irq_id, count, ready %, halt %, kill %, stops on error
    tbl[0]  = '{PC_BOOT,      32'h0000_1002, 5'd0,  8,  100, 0,  0,  1'b0};
    tbl[1]  = '{PC_JUMP,      32'h0000_2000, 5'd0,  6,  100, 0,  0,  1'b0};
    tbl[2]  = '{PC_BRANCH,    32'h0000_2400, 5'd0,  6,  70,  10, 0,  1'b0};
    tbl[3]  = '{PC_EXCEPTION, 32'h0000_5A44, 5'd0,  4,  100, 0,  0,  1'b0};
    tbl[4]  = '{PC_IRQ,       32'h0000_5A00, 5'd3,  3,  100, 0,  0,  1'b0};
    tbl[5]  = '{PC_IRQ,       32'h0000_5A00, 5'd17, 3,  100, 0,  0,  1'b0};
    tbl[6]  = '{PC_IRQ,       32'h0000_5A00, 5'd31, 2,  100, 0,  0,  1'b0};
    tbl[7]  = '{PC_MRET,      32'h0000_3006, 5'd0,  5,  100, 0,  0,  1'b0};
    tbl[8]  = '{PC_JUMP,      32'h0000_6000, 5'd0,  20, 40,  20, 0,  1'b0};
    tbl[9]  = '{PC_BRANCH,    32'h0000_7000, 5'd0,  12, 80,  0,  25, 1'b0};
    tbl[10] = '{PC_JUMP,      32'h0000_8FF8, 5'd0,  3,  100, 0,  0,  1'b1};
    tbl[11] = '{PC_JUMP,      32'h0000_4000, 5'd0,  8,  90,  10, 0,  1'b0};
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial
  begin
    pc_mux_e     mux;
    int          err_start;
    ctrl     = '0;
    targets  = '0;
    id_ready = 1'b0;
    load_table();
    tick();
    while (!rst_n)
    begin
      tick();
    end
    // Everything idle before the first redirect
    check("req_o after reset", 66'(req), 66'(0));
    check("if_valid_o after reset", 66'(if_valid), 66'(0));
    check("instr_valid after reset", 66'(pipe_out.instr_valid), 66'(0));
    check("instr after reset", 66'(pipe_out.instr), 66'(`FETCH_INSTR_RESET));
    check("csr_mtvec_init_o after reset", 66'(mtvec_init), 66'(0));
    check("if_busy_o after reset", 66'(if_busy), 66'(0));
    for (int e = 0; e < NUM_STIM; e++)
    begin
      mux       = tbl[e].mux;
      exp_t     = redirect_target(tbl[e]);
      err_start = errors;
      // Redirect with the head killed, as the core controller does
      ctrl.pc_set  <= 1'b1;
      ctrl.pc_mux  <= tbl[e].mux;
      ctrl.irq_id  <= tbl[e].irq_id;
      ctrl.kill_if <= 1'b1;
      ctrl.halt_if <= 1'b0;
      targets      <= make_targets(tbl[e]);
      tick();
      ctrl.pc_set  <= 1'b0;
      ctrl.kill_if <= 1'b0;
      while (got < tbl[e].n)
      begin
        id_ready     <= pct_hit(tbl[e].ready_pct);
        ctrl.halt_if <= pct_hit(tbl[e].halt_pct);
        // Kills start after the target itself was seen
        ctrl.kill_if <= (got > 0) && pct_hit(tbl[e].kill_pct);
        tick();
      end
      if (tbl[e].stop)
      begin
        // Decode stays ready, yet nothing may follow the error
        repeat (25)
        begin
          id_ready     <= 1'b1;
          ctrl.halt_if <= 1'b0;
          ctrl.kill_if <= 1'b0;
          tick();
        end
        check("count after bus error", 66'(got), 66'(tbl[e].n));
        check("last entry bus_err", 66'(last_err), 66'(1));
      end
      else
      begin
        check("bus_err in normal run", 66'(last_err), 66'(0));
      end
      check("first address after redirect", 66'(first_pc), 66'(exp_t));
      $display("entry %0d %s target %h first %h delivered %0d killed %0d errors %0d",
               e, mux.name(), exp_t, first_pc, got, kills, errors - err_start);
    end
    $display("%0d entries, %0d checks, %0d errors", NUM_STIM, checks, errors);
    if (errors == 0)
    begin
      $display("ALL CHECKS PASSED");
    end
    else
    begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Watchdog, about 200 cycles per table entry plus reset
  initial
  begin
    repeat (NUM_STIM * 200 + 20) @(posedge clk);
    $display("Timeout: the fetch stage stopped delivering instructions");
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire
